// File: hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bru_pkg::bru_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output bru_pkg::bru_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i
);

  import bru_pkg::*;

  logic     taken;
  tgt_res_t tgt;

  // Condition evaluation
  flag_compare i_flag_compare (
    .rs1_i    (req_i.rs1),
    .rs2_i    (req_i.rs2),
    .bpu_op_i (req_i.bpu_op),
    .sys_op_i (req_i.sys_op),
    .taken_o  (taken)
  );

  // Target, link and alignment, in parallel with the compare
  target_gen i_target_gen (
    .req_i (req_i),
    .tgt_o (tgt)
  );

  redirect_merge i_redirect_merge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .taken_i      (taken),
    .tgt_i        (tgt),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

// File: hdl/bru_pkg.sv
package bru_pkg;

  // RV32 datapath
  localparam int XLEN     = 32;
  localparam int BPU_OP_W = 4;
  localparam int SYS_OP_W = 2;

  // Size of one instruction, step to the sequential pc
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

  // Branch and jump opcodes
  typedef enum logic [BPU_OP_W-1:0] {
    BPU_NONE = 4'd0,
    BPU_BEQ  = 4'd1,
    BPU_BNE  = 4'd2,
    BPU_BLT  = 4'd3,
    BPU_BGE  = 4'd4,
    BPU_BLTU = 4'd5,
    BPU_BGEU = 4'd6,
    BPU_JAL  = 4'd7,
    BPU_JALR = 4'd8
  } bpu_op_e;

  // System opcodes that redirect to a CSR value
  typedef enum logic [SYS_OP_W-1:0] {
    SYS_NONE  = 2'd0,
    SYS_ECALL = 2'd1,   // Destination is mtvec
    SYS_MRET  = 2'd2    // Destination is mepc
  } sys_op_e;

  // Decoded request from the execute stage
  typedef struct packed {
    bpu_op_e         bpu_op;
    sys_op_e         sys_op;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr_rdata;
  } bru_req_t;

  // Partial result of the target path
  typedef struct packed {
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] link;
    logic            misaligned;  // Not yet gated by taken
  } tgt_res_t;

  // Final redirect decision
  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] link;
    logic            misaligned;
  } bru_resp_t;

endpackage

// File: hdl/flag_compare.sv
`timescale 1ns/1ps

module flag_compare (
  input  logic [bru_pkg::XLEN-1:0] rs1_i,
  input  logic [bru_pkg::XLEN-1:0] rs2_i,
  input  bru_pkg::bpu_op_e         bpu_op_i,
  input  bru_pkg::sys_op_e         sys_op_i,
  output logic                     taken_o
);

  import bru_pkg::*;

  logic            carry;
  logic [XLEN-1:0] diff;
  logic            zero_f;
  logic            sign_f;
  logic            ovf_f;
  logic            borrow_f;
  logic            equal;
  logic            signed_lt;
  logic            unsigned_lt;
  logic            branch_taken;
  logic            sys_taken;

  // rs1 - rs2 as rs1 + ~rs2 + 1, carry out kept
  assign {carry, diff} = {1'b0, rs1_i} + {1'b0, ~rs2_i} + {{XLEN{1'b0}}, 1'b1};

  assign zero_f   = ~(|diff);
  assign sign_f   = diff[XLEN-1];
  // Overflow only when operand signs differ and the result flips away from rs1
  assign ovf_f    = (rs1_i[XLEN-1] ^ rs2_i[XLEN-1]) & (diff[XLEN-1] ^ rs1_i[XLEN-1]);
  assign borrow_f = ~carry;       // No carry out means rs1 < rs2 unsigned

  assign equal       = zero_f;
  assign signed_lt   = sign_f ^ ovf_f;
  assign unsigned_lt = borrow_f;

  always_comb begin
    case (bpu_op_i)
      BPU_BEQ:  branch_taken = equal;
      BPU_BNE:  branch_taken = ~equal;
      BPU_BLT:  branch_taken = signed_lt;
      BPU_BGE:  branch_taken = ~signed_lt;
      BPU_BLTU: branch_taken = unsigned_lt;
      BPU_BGEU: branch_taken = ~unsigned_lt;
      BPU_JAL,
      BPU_JALR: branch_taken = 1'b1;  // Jumps are unconditional
      default:  branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (sys_op_i)
      SYS_ECALL,
      SYS_MRET: sys_taken = 1'b1;
      default:  sys_taken = 1'b0;
    endcase
  end

  assign taken_o = branch_taken | sys_taken;

endmodule

// File: hdl/redirect_merge.sv
`timescale 1ns/1ps

module redirect_merge (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bru_pkg::bru_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic               taken_i,
  input  bru_pkg::tgt_res_t  tgt_i,
  output bru_pkg::bru_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i
);

  import bru_pkg::*;

  logic [XLEN-1:0] seq_pc;
  logic            accept;
  bru_resp_t       resp_d;
  bru_resp_t       resp_q;
  logic            valid_q;

  assign seq_pc = req_i.pc + INSN_BYTES;  // Fall-through address

  always_comb begin
    resp_d.taken      = taken_i;
    resp_d.link       = tgt_i.link;
    resp_d.misaligned = taken_i & tgt_i.misaligned;
    if (taken_i) begin
      resp_d.next_pc = tgt_i.target;
    end else begin
      resp_d.next_pc = seq_pc;
    end
  end

  // Free slot, or the held response leaves this cycle
  assign req_ready_o = ~valid_q | resp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      valid_q <= 1'b0;  // Drained with nothing behind it
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = valid_q;

  // A stalled response must not move
  property p_resp_hold;
    @(posedge clk_i) disable iff (rst_i)
      (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o));
  endproperty
  a_resp_hold: assert property (p_resp_hold)
    else $error("resp_o changed while stalled");

  // Decode never issues a branch and a system op together
  property p_one_op_class;
    @(posedge clk_i) disable iff (rst_i)
      accept |-> !((req_i.bpu_op != BPU_NONE) && (req_i.sys_op != SYS_NONE));
  endproperty
  a_one_op_class: assert property (p_one_op_class)
    else $error("request carries both bpu_op and sys_op");

  property p_reset_clears_valid;
    @(posedge clk_i) rst_i |=> !resp_valid_o;
  endproperty
  a_reset_clears_valid: assert property (p_reset_clears_valid)
    else $error("resp_valid_o high after reset");

endmodule

// File: hdl/target_gen.sv
`timescale 1ns/1ps

module target_gen (
  input  bru_pkg::bru_req_t req_i,
  output bru_pkg::tgt_res_t tgt_o
);

  import bru_pkg::*;

  logic            is_jalr;
  logic            is_sys;
  logic            is_bpu;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] jump_tgt;
  logic [XLEN-1:0] target;

  assign is_jalr = (req_i.bpu_op == BPU_JALR);
  assign is_bpu  = (req_i.bpu_op != BPU_NONE);
  assign is_sys  = (req_i.sys_op == SYS_ECALL) || (req_i.sys_op == SYS_MRET);

  // One adder shared by branches, JAL and JALR
  assign base = is_jalr ? req_i.rs1 : req_i.pc;
  assign sum  = base + req_i.imm;

  // JALR drops bit 0 of the sum
  assign jump_tgt = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

  // Trap entry and return take the CSR value as is
  always_comb begin
    if (is_sys) begin
      target = req_i.csr_rdata;
    end else begin
      target = jump_tgt;
    end
  end

  assign tgt_o.target = target;
  assign tgt_o.link   = req_i.pc + INSN_BYTES;

  // Only bit 1 matters, no compressed instructions
  // System targets never report misalignment
  assign tgt_o.misaligned = is_bpu & target[1];

endmodule

// File: list.f
hdl/bru_pkg.sv
hdl/flag_compare.sv
hdl/target_gen.sv
hdl/redirect_merge.sv
hdl/branch_unit.sv
test/tb_branch_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_branch_unit --Mdir "$BUILD_DIR" -o tb_branch_unit -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_branch_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

// File: test/branch_vectors.txt
// grp bpu_op sys_op pc imm rs1 rs2 csr_rdata | taken next_pc link misaligned
// grp: 0 branches, 1 jumps, 2 system, 3 misaligned
// Conditional branches, target 00001040
0 1 0 00001000 00000040 00000005 00000005 00000000 1 00001040 00001004 0
0 1 0 00001000 00000040 00000005 00000006 00000000 0 00001004 00001004 0
0 2 0 00001000 00000040 00000005 00000006 00000000 1 00001040 00001004 0
0 2 0 00001000 00000040 00000005 00000005 00000000 0 00001004 00001004 0
0 3 0 00001000 00000040 80000000 7fffffff 00000000 1 00001040 00001004 0
0 3 0 00001000 00000040 7fffffff 80000000 00000000 0 00001004 00001004 0
0 4 0 00001000 00000040 80000000 7fffffff 00000000 0 00001004 00001004 0
0 4 0 00001000 00000040 7fffffff 80000000 00000000 1 00001040 00001004 0
0 5 0 00001000 00000040 80000000 7fffffff 00000000 0 00001004 00001004 0
0 5 0 00001000 00000040 7fffffff 80000000 00000000 1 00001040 00001004 0
0 6 0 00001000 00000040 80000000 7fffffff 00000000 1 00001040 00001004 0
0 6 0 00001000 00000040 7fffffff 80000000 00000000 0 00001004 00001004 0
// Backward target 00001ff0, signed and unsigned results differ
0 3 0 00002000 fffffff0 ffffffff 00000001 00000000 1 00001ff0 00002004 0
0 5 0 00002000 fffffff0 ffffffff 00000001 00000000 0 00002004 00002004 0
0 4 0 00002000 fffffff0 ffffffff ffffffff 00000000 1 00001ff0 00002004 0
0 6 0 00002000 fffffff0 00000000 00000001 00000000 0 00002004 00002004 0
0 5 0 00002000 fffffff0 00000000 00000001 00000000 1 00001ff0 00002004 0
0 4 0 00002000 fffffff0 00000001 ffffffff 00000000 1 00001ff0 00002004 0
// Jumps
1 7 0 00003000 00000100 00000000 00000000 00000000 1 00003100 00003004 0
1 7 0 00003010 fffff000 00000000 00000000 00000000 1 00002010 00003014 0
1 8 0 00004000 00000005 00010000 00000000 00000000 1 00010004 00004004 0
1 8 0 00004004 fffffff9 00020008 00000000 00000000 1 00020000 00004008 0
// ECALL and MRET go to csr_rdata
2 0 1 00005000 00000000 00000000 00000000 00000100 1 00000100 00005004 0
2 0 2 00005004 00000000 00000000 00000000 00001002 1 00001002 00005008 0
2 0 1 00005008 00000010 00000007 00000003 80000003 1 80000003 0000500c 0
// Targets with bit 1 set, taken and not taken
3 1 0 00006000 00000006 00000001 00000001 00000000 1 00006006 00006004 1
3 1 0 00006000 00000006 00000001 00000002 00000000 0 00006004 00006004 0
3 7 0 00006000 0000000a 00000000 00000000 00000000 1 0000600a 00006004 1
3 8 0 00006100 ffffffff 80000000 00000000 00000000 1 7ffffffe 00006104 1
3 8 0 00006104 00000002 00000001 00000000 00000000 1 00000002 00006108 1
3 2 0 00006200 fffffffe 00000003 00000003 00000000 0 00006204 00006204 0
3 2 0 00006200 fffffffe 00000003 00000004 00000000 1 000061fe 00006204 1
3 5 0 00006300 00000002 00000000 ffffffff 00000000 1 00006302 00006304 1
3 6 0 00006300 00000002 00000000 ffffffff 00000000 0 00006304 00006304 0
3 0 0 00006400 00000002 00000000 00000000 00000000 0 00006404 00006404 0
3 3 0 00006500 00000001 ffffffff 00000000 00000000 1 00006501 00006504 0

// File: test/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit;

  import bru_pkg::*;

  localparam int NCOL    = 12;        // Words per vector line
  localparam int MAX_VEC = 64;
  localparam int NGRP    = 7;
  localparam int G_BR    = 0;
  localparam int G_JMP   = 1;
  localparam int G_SYS   = 2;
  localparam int G_MIS   = 3;
  localparam int G_LAT   = 4;
  localparam int G_HS    = 5;
  localparam int G_RST   = 6;
  localparam logic [31:0] SEED = 32'he057_d308;

  logic      clk_i;
  logic      rst_i;
  bru_req_t  req_i;
  logic      req_valid_i;
  logic      req_ready_o;
  bru_resp_t resp_o;
  logic      resp_valid_o;
  logic      resp_ready_i;

  logic [31:0] vec_mem [0:MAX_VEC*NCOL-1];
  int          nv;
  int          exp_q[$];
  int          acc_q[$];       // Acceptance cycle of each outstanding request
  int          cycle;
  int          cur_idx;
  int          resp_cnt;
  int          extra_err;
  int          mon_idx;
  int          mon_grp;
  logic        held_valid;
  logic        stall_mode;
  logic [31:0] gap_state;
  logic [31:0] rdy_state;
  int          chk_cnt [NGRP];
  int          err_cnt [NGRP];
  string       grp_name [NGRP];

  branch_unit i_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input int grp, input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt[grp]++;
    if (got !== exp) begin
      err_cnt[grp]++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int vector_group(input int idx);
    return int'(vec_mem[idx*NCOL][2:0]);
  endfunction

  task automatic load_req(input int idx);
    int b;
    b = idx * NCOL;
    req_i.bpu_op    = bpu_op_e'(vec_mem[b+1][3:0]);
    req_i.sys_op    = sys_op_e'(vec_mem[b+2][1:0]);
    req_i.pc        = vec_mem[b+3];
    req_i.imm       = vec_mem[b+4];
    req_i.rs1       = vec_mem[b+5];
    req_i.rs2       = vec_mem[b+6];
    req_i.csr_rdata = vec_mem[b+7];
  endtask

  task automatic compare_resp(input int idx, input int grp);
    int b;
    b = idx * NCOL;
    check_val(grp, $sformatf("vec %0d taken", idx), 32'(resp_o.taken), vec_mem[b+8]);
    check_val(grp, $sformatf("vec %0d next_pc", idx), resp_o.next_pc, vec_mem[b+9]);
    check_val(grp, $sformatf("vec %0d link", idx), resp_o.link, vec_mem[b+10]);
    check_val(grp, $sformatf("vec %0d misaligned", idx), 32'(resp_o.misaligned),
              vec_mem[b+11]);
  endtask

  // Random back-pressure only in the stall pass
  always @(posedge clk_i) begin
    #1;
    if (stall_mode) begin
      rdy_state = xorshift(rdy_state);
      resp_ready_i = rdy_state[3];
    end else begin
      resp_ready_i = 1'b1;
    end
  end

  // Handshakes are sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (resp_valid_o) begin
        if (resp_ready_i) begin
          resp_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("Response seen at %0t ns with no request outstanding", $time);
          extra_err++;
        end else begin
          mon_idx = exp_q[0];
          mon_grp = stall_mode ? G_HS : vector_group(mon_idx);
          compare_resp(mon_idx, mon_grp);     // Repeated on stalled cycles to catch a moving payload
          if (!held_valid) begin
            check_val(stall_mode ? G_HS : G_LAT, $sformatf("vec %0d latency", mon_idx),
                      32'(cycle - acc_q[0]), 32'd1);
          end
          if (resp_ready_i) begin
            mon_idx = exp_q.pop_front();
            mon_idx = acc_q.pop_front();
          end
        end
      end else if (held_valid) begin
        $display("resp_valid_o dropped at %0t ns while the response was stalled", $time);
        extra_err++;
      end
      held_valid = resp_valid_o && !resp_ready_i;
      if (req_valid_i && req_ready_o) begin
        exp_q.push_back(cur_idx);
        acc_q.push_back(cycle);
      end
    end
  end

  task automatic run_pass(input logic random_gaps);
    int gap;
    resp_cnt = 0;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < nv; i++) begin
      gap = 0;
      if (random_gaps) begin
        gap_state = xorshift(gap_state);
        gap = int'(gap_state[1:0]);
      end
      req_valid_i = 1'b0;
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
      load_req(i);
      cur_idx = i;
      req_valid_i = 1'b1;
      do @(negedge clk_i); while (!req_ready_o);
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);  // Room for a stray response to show up
    check_val(random_gaps ? G_HS : G_LAT, "response count", 32'(resp_cnt), 32'(nv));
  endtask

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout: the run ended before all responses arrived");
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic print_group(input int g);
    $display("%-12s %0d checks, %0d errors", grp_name[g], chk_cnt[g], err_cnt[g]);
  endtask

  initial begin
    int total_chk;
    int total_err;
    rst_i        = 1'b1;
    req_i        = '0;
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    stall_mode   = 1'b0;
    held_valid   = 1'b0;
    cycle        = 0;
    cur_idx      = 0;
    extra_err    = 0;
    gap_state    = SEED;
    rdy_state    = ~SEED;      // Separate stream for resp_ready_i
    grp_name     = '{"branches", "jumps", "system", "misaligned", "latency", "handshake",
                     "reset"};
    for (int g = 0; g < NGRP; g++) begin
      chk_cnt[g] = 0;
      err_cnt[g] = 0;
    end
    for (int i = 0; i < MAX_VEC*NCOL; i++) vec_mem[i] = {16'hffff, 16'(i)};
    $readmemh("test/branch_vectors.txt", vec_mem);
    nv = 0;
    while (nv < MAX_VEC && vec_mem[nv*NCOL][31:16] != 16'hffff) nv++;
    if (nv == 0) begin
      $display("No vectors could be read from test/branch_vectors.txt");
      extra_err++;
    end
    fork
      watchdog(nv * 20 * 20 + 16 * 20);
    join_none

    repeat (16) @(posedge clk_i);
    #1 rst_i = 1'b0;
    @(negedge clk_i);
    check_val(G_RST, "resp_valid_o after reset", 32'(resp_valid_o), 32'd0);
    check_val(G_RST, "req_ready_o after reset", 32'(req_ready_o), 32'd1);
    print_group(G_RST);

    run_pass(1'b0);
    for (int g = G_BR; g <= G_LAT; g++) print_group(g);

    stall_mode = 1'b1;
    run_pass(1'b1);
    print_group(G_HS);

    total_chk = 0;
    total_err = extra_err;
    for (int g = 0; g < NGRP; g++) begin
      total_chk += chk_cnt[g];
      total_err += err_cnt[g];
    end
    $display("Total: %0d checks, %0d errors", total_chk, total_err);
    if (total_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
